/* build.f */
design/prio_pkg.sv
design/prio_capture.sv
design/seg_prio_enc.sv
design/prio_merge.sv
design/prio_enc_64.sv
tb/prio_enc_64_tb.sv

/* design/prio_capture.sv */
// request capture and segment split
module prio_capture (
  input  logic                                                clk,
  input  logic                                                reset,
  input  logic                                                req_valid,
  input  prio_pkg::req_t                                      req,
  output logic                                                seg_valid,
  output logic [prio_pkg::tag_width-1:0]                      seg_tag,
  output logic [prio_pkg::num_segs-1:0][prio_pkg::seg_width-1:0] segs
);

  // captured request payload
  prio_pkg::req_t req_q;

  // vector widened to a whole number of segments
  logic [prio_pkg::num_segs*prio_pkg::seg_width-1:0] padded;

  // valid strobe, the only control state here
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      seg_valid <= 1'b0;
    end
    else
    begin
      seg_valid <= req_valid;
    end
  end

  // payload only loads on an accepted request
  always_ff @(posedge clk)
  begin
    if (req_valid)
    begin
      req_q <= req;
    end
  end

  assign seg_tag = req_q.tag;

  // zeros above bit 63 fill the top segment
  assign padded = {
    {(prio_pkg::num_segs*prio_pkg::seg_width-prio_pkg::vec_width){1'b0}},
    req_q.bits
  };

  // segment k covers bits k*12 up to k*12+11
  always_comb
  begin
    for (int k = 0; k < prio_pkg::num_segs; k++)
    begin
      segs[k] = padded[k*prio_pkg::seg_width +: prio_pkg::seg_width];
    end
  end

  // a strobed request must be fully defined
  a_req_known: assert property (
    @(posedge clk) disable iff (reset)
    req_valid |-> !$isunknown(req)
  );

endmodule

/* design/prio_enc_64.sv */
// pipelined 64-bit first-set-bit finder
module prio_enc_64 (
  input  logic           clk,
  input  logic           reset,
  input  logic           req_valid,
  input  prio_pkg::req_t req,
  output logic           res_valid,
  output prio_pkg::res_t res
);

  // capture to encoders
  logic                                                  seg_valid;
  logic [prio_pkg::tag_width-1:0]                        seg_tag;
  logic [prio_pkg::num_segs-1:0][prio_pkg::seg_width-1:0] segs;

  // encoders to merge
  prio_pkg::seg_res_t [prio_pkg::num_segs-1:0] seg_res;

  // stage 1, request register and split
  prio_capture i_capture (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .seg_valid (seg_valid),
    .seg_tag   (seg_tag),
    .segs      (segs)
  );

  // stage 2, one identical encoder per segment
  generate
    for (genvar k = 0; k < prio_pkg::num_segs; k++)
    begin : g_seg
      seg_prio_enc i_enc (
        .clk (clk),
        .seg (segs[k]),
        .res (seg_res[k])
      );
    end
  endgenerate

  // stage 3, pick the lowest segment and add its offset
  prio_merge i_merge (
    .clk       (clk),
    .reset     (reset),
    .seg_valid (seg_valid),
    .seg_tag   (seg_tag),
    .seg_res   (seg_res),
    .res_valid (res_valid),
    .res       (res)
  );

endmodule

/* design/prio_merge.sv */
// segment merge and result register
module prio_merge (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      seg_valid,
  input  logic [prio_pkg::tag_width-1:0]            seg_tag,
  input  prio_pkg::seg_res_t [prio_pkg::num_segs-1:0] seg_res,
  output logic                                      res_valid,
  output prio_pkg::res_t                            res
);

  // valid and tag delayed to line up with the encoder registers
  logic                           valid_q;
  logic [prio_pkg::tag_width-1:0] tag_q;

  // merged result before the output register
  logic                           found_c;
  logic [prio_pkg::idx_width-1:0] index_c;
  int                             gidx;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid_q   <= 1'b0;
      res_valid <= 1'b0;
    end
    else
    begin
      valid_q   <= seg_valid;
      res_valid <= valid_q;
    end
  end

  always_ff @(posedge clk)
  begin
    tag_q <= seg_tag;
  end

  // lowest non-empty segment wins, walking down so it is assigned last
  always_comb
  begin
    found_c = 1'b0;
    index_c = prio_pkg::none_index;
    gidx    = 0;
    for (int k = prio_pkg::num_segs - 1; k >= 0; k--)
    begin
      if (seg_res[k].found)
      begin
        // segment base offset plus local index
        gidx    = k * prio_pkg::seg_width + int'(seg_res[k].lidx);
        found_c = 1'b1;
        index_c = gidx[prio_pkg::idx_width-1:0];
      end
    end
  end

  // result payload
  always_ff @(posedge clk)
  begin
    res.tag   <= tag_q;
    res.found <= found_c;
    res.index <= index_c;
  end

  // index is never past the empty marker
  a_index_range: assert property (
    @(posedge clk) disable iff (reset)
    res_valid |-> (res.index <= prio_pkg::none_index)
  );

  // found and a real index go together
  a_found_index: assert property (
    @(posedge clk) disable iff (reset)
    res_valid |-> (res.found == (res.index < prio_pkg::none_index))
  );

endmodule

/* design/prio_pkg.sv */
// priority encoder shared definitions
package prio_pkg;

  // request vector geometry
  localparam int vec_width = 64;

  // the vector is cut into equal segments, the last one padded
  localparam int seg_width = 12;
  localparam int num_segs  = 6;

  // global index must reach 64 for the empty case
  localparam int idx_width = 7;

  // index inside one segment, 0 to 11
  localparam int lidx_width = 4;

  // opaque request tag, carried through unchanged
  localparam int tag_width = 8;

  // reported when no bit is set
  localparam logic [idx_width-1:0] none_index = 7'd64;

  // incoming request
  typedef struct packed {
    logic [tag_width-1:0] tag;
    logic [vec_width-1:0] bits;
  } req_t;

  // per segment result from one encoder
  typedef struct packed {
    logic                  found;
    logic [lidx_width-1:0] lidx;
  } seg_res_t;

  // final result returned to the requester
  typedef struct packed {
    logic [tag_width-1:0] tag;
    logic                 found;
    logic [idx_width-1:0] index;
  } res_t;

endpackage

/* design/seg_prio_enc.sv */
// single segment lowest-bit encoder
module seg_prio_enc (
  input  logic                          clk,
  input  logic [prio_pkg::seg_width-1:0] seg,
  output prio_pkg::seg_res_t            res
);

  // combinational result before the register
  logic                            found_c;
  logic [prio_pkg::lidx_width-1:0] lidx_c;

  // any bit set in this segment
  assign found_c = |seg;

  // scan from the top down so the lowest set bit is the last to win
  always_comb
  begin
    lidx_c = '0;
    for (int i = prio_pkg::seg_width - 1; i >= 0; i--)
    begin
      if (seg[i])
      begin
        lidx_c = i[prio_pkg::lidx_width-1:0];
      end
    end
  end

  // registered every cycle; merge qualifies it with its own valid
  always_ff @(posedge clk)
  begin
    res.found <= found_c;
    res.lidx  <= lidx_c;
  end

  // local index stays inside the segment
  a_lidx_range: assert property (
    @(posedge clk)
    res.found |-> (res.lidx < prio_pkg::seg_width)
  );

endmodule

/* tb/prio_enc_64_tb.sv */
// first-set-bit finder testbench
module prio_enc_64_tb;

  // run limit, well above the ~700 cycles the tests need
  localparam int max_cycles = 2000;

  // pipeline depth from request edge to result
  localparam int latency = 3;

  logic           clk;
  logic           reset;
  logic           req_valid;
  prio_pkg::req_t req;
  logic           res_valid;
  prio_pkg::res_t res;

  int cycle   = 0;
  int errors  = 0;
  int checks  = 0;
  int results = 0;
  int seed;

  // expected results and the cycle each request was sent
  prio_pkg::res_t exp_q[$];
  int             sent_q[$];

  prio_enc_64 i_dut (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .res_valid (res_valid),
    .res       (res)
  );

  always #5 clk = ~clk;

  // cycle count and run limit
  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles)
    begin
      $display("run timed out after %0d cycles", cycle);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic flag_error(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // position of the lowest set bit, 64 for an empty vector
  function automatic int lowest_set(input logic [63:0] v);
    for (int i = 0; i < 64; i++)
    begin
      if (v[i])
        return i;
    end
    return 64;
  endfunction

  // outputs are sampled half a cycle away from the edge that moves them
  always @(negedge clk)
  begin : watch_results
    prio_pkg::res_t exp;
    int             sent;
    if (res_valid === 1'b1)
    begin
      if (exp_q.size() == 0)
      begin
        flag_error("result appeared while no request was outstanding");
      end
      else
      begin
        exp  = exp_q.pop_front();
        sent = sent_q.pop_front();
        compare("res.tag", exp.tag, res.tag);
        compare("res.found", exp.found, res.found);
        compare("res.index", exp.index, res.index);
        compare("latency", latency, cycle - sent);
        results++;
      end
    end
    else if (res_valid !== 1'b0 && cycle > 0)
    begin
      flag_error("res_valid is unknown");
    end
  end

  // one request this cycle, expected result queued
  task automatic drive_req(input logic [7:0] tag, input logic [63:0] bits);
    prio_pkg::res_t exp;
    int             idx;
    idx       = lowest_set(bits);
    exp.tag   = tag;
    exp.found = (idx < 64);
    exp.index = 7'(idx);
    req_valid = 1'b1;
    req.tag   = tag;
    req.bits  = bits;
    exp_q.push_back(exp);
    sent_q.push_back(cycle);
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycle;
    req_valid = 1'b0;
    @(posedge clk);
    #1;
  endtask

  // wait for outstanding results, then a little longer for extras
  task automatic drain;
    int n;
    n = 0;
    req_valid = 1'b0;
    while (exp_q.size() != 0 && n < latency + 5)
    begin
      @(posedge clk);
      #1;
      n++;
    end
    if (exp_q.size() != 0)
    begin
      flag_error($sformatf("%0d expected results never appeared", exp_q.size()));
      exp_q.delete();
      sent_q.delete();
    end
    repeat (2) idle_cycle();
  endtask

  task automatic test_done(input string name, input int err0);
    $display("%s finished with %0d errors", name, errors - err0);
  endtask

  // every bit position alone, covering all segment offsets
  task automatic one_hot_sweep;
    int err0;
    err0 = errors;
    for (int i = 0; i < 64; i++)
    begin
      drive_req(8'(i), 64'd1 << i);
    end
    drain();
    test_done("one_hot_sweep", err0);
  endtask

  task automatic empty_vector;
    int err0;
    err0 = errors;
    drive_req(8'h5a, 64'h0);
    idle_cycle();
    drive_req(8'ha5, 64'h0);
    drain();
    test_done("empty_vector", err0);
  endtask

  // random vectors, some forced to start in a chosen segment
  task automatic lowest_bit_wins;
    int          err0;
    int          kind;
    int          seg;
    int          pos;
    logic [63:0] v;
    err0 = errors;
    for (int i = 0; i < 200; i++)
    begin
      kind = i % 4;
      v    = {$random(seed), $random(seed)};
      if (kind == 1 || kind == 3)
      begin
        // sparse, a few bits spread over several segments
        v = v & {$random(seed), $random(seed)} & {$random(seed), $random(seed)};
      end
      if (kind >= 2)
      begin
        seg = ($random(seed) & 32'h7fff_ffff) % 6;
        v   = v & (64'hffff_ffff_ffff_ffff << (seg * 12));
        pos = seg * 12 + ($random(seed) & 32'h7fff_ffff) % ((seg == 5) ? 4 : 12);
        v[pos] = 1'b1;
      end
      drive_req(8'(i), v);
      if (($random(seed) & 7) == 0)
        idle_cycle();
    end
    drain();
    test_done("lowest_bit_wins", err0);
  endtask

  // full rate stream, results must come back one per cycle in order
  task automatic back_to_back_stream;
    int          err0;
    int          res0;
    logic [63:0] v;
    err0 = errors;
    res0 = results;
    for (int i = 0; i < 300; i++)
    begin
      v = {$random(seed), $random(seed)} & {$random(seed), $random(seed)};
      drive_req(8'(i), v);
    end
    drain();
    compare("result count", 300, results - res0);
    test_done("back_to_back_stream", err0);
  endtask

  // in-flight requests are dropped by a mid-run reset
  task automatic reset_behavior;
    int err0;
    err0 = errors;
    req_valid = 1'b0;
    repeat (4)
    begin
      compare("res_valid", 0, res_valid);
      idle_cycle();
    end
    drive_req(8'hd0, 64'h0000_0000_0000_0100);
    drive_req(8'hd1, 64'h8000_0000_0000_0000);
    reset     = 1'b1;
    req_valid = 1'b0;
    repeat (4)
    begin
      @(posedge clk);
      #1;
      compare("res_valid", 0, res_valid);
    end
    // both requests should still be waiting, none came out
    compare("dropped requests", 2, exp_q.size());
    exp_q.delete();
    sent_q.delete();
    reset = 1'b0;
    repeat (4)
    begin
      @(posedge clk);
      #1;
      compare("res_valid", 0, res_valid);
    end
    drive_req(8'hd2, 64'h0000_0400_0000_0000);
    drain();
    test_done("reset_behavior", err0);
  endtask

  initial
  begin
    clk       = 1'b0;
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    seed      = 32'hc083_50a6;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    one_hot_sweep();
    empty_vector();
    lowest_bit_wins();
    back_to_back_stream();
    reset_behavior();

    $display("summary: %0d checks, %0d results, %0d errors", checks, results, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule
